// ==== hw/rvx_pkg.sv ====
`default_nettype none

package rvx_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported RV32I groups.
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef struct packed {
        logic            reg_write;
        alu_op_e         alu_op;
        logic [xlen-1:0] opa;
        logic [xlen-1:0] opb;      // Already holds the immediate when one applies.
        reg_addr_t       rd;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        logic            rs1_used;
        logic            rs2_used;
    } de_payload_t;

    typedef struct packed {
        logic            reg_write;
        reg_addr_t       rd;
        logic [xlen-1:0] result;
    } ew_payload_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        reg_addr_t       rd;
        logic [xlen-1:0] value;
    } fwd_t;

    localparam logic [7:0] addr_instr    = 8'h00;
    localparam logic [7:0] addr_status   = 8'h04;
    localparam logic [7:0] addr_reg_base = 8'h80;   // x0 to x31 up to 0xFC.

endpackage

`default_nettype wire

// ==== hw/stage_register.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_register #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush = 1'b0,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // A flushed slot turns into a bubble with no write enable.
    always_ff @(posedge clk) begin
        if (flush) begin
            out_data <= '0;
        end else begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/apb_front.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_front #(
    parameter int queue_depth = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [7:0]                paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic [31:0]               instr,
    output logic                      instr_valid,
    input  logic                      instr_take,
    input  logic                      illegal,
    input  logic                      pipe_busy,
    output rvx_pkg::reg_addr_t        dbg_addr,
    input  logic [rvx_pkg::xlen-1:0]  rdata_dbg,
    input  logic [15:0]               retired_count
);

    localparam int ptr_w = $clog2(queue_depth);

    logic [31:0]    queue_mem [queue_depth];
    logic [ptr_w:0] wr_ptr;
    logic [ptr_w:0] rd_ptr;
    logic           queue_empty;
    logic           queue_full;
    logic [15:0]    illegal_count;
    logic           access;
    logic           is_instr;
    logic           is_status;
    logic           is_reg;
    logic           bad;
    logic           drained;
    logic           done;
    logic           push;
    logic [31:0]    read_data;

    // The extra pointer bit tells a full queue from an empty one.
    assign queue_empty = wr_ptr == rd_ptr;
    assign queue_full  = (wr_ptr - rd_ptr) == (ptr_w + 1)'(queue_depth);

    assign instr       = queue_mem[rd_ptr[ptr_w-1:0]];
    assign instr_valid = !queue_empty;

    assign access    = psel && penable && !pready;  // Access phase still waiting for a response.
    assign is_instr  = paddr == rvx_pkg::addr_instr;
    assign is_status = paddr == rvx_pkg::addr_status;
    assign is_reg    = paddr >= rvx_pkg::addr_reg_base && paddr[1:0] == 2'b00;
    assign bad       = pwrite ? !is_instr : !(is_status || is_reg);
    assign drained   = queue_empty && !pipe_busy;   // Reads see every earlier write retired.
    assign done      = access && (bad || (pwrite ? !queue_full : drained));
    assign push      = done && pwrite && !bad;

    assign dbg_addr  = paddr[6:2];
    assign read_data = is_status ? {illegal_count, retired_count} : rdata_dbg;

    always_ff @(posedge clk) begin
        if (reset) begin
            pready        <= 1'b0;
            pslverr       <= 1'b0;
            prdata        <= '0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            illegal_count <= '0;
        end else begin
            pready  <= done;            // Response goes out the cycle after the decision.
            pslverr <= done && bad;
            if (done && !pwrite) begin
                prdata <= bad ? '0 : read_data;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (instr_take && !queue_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (illegal) begin
                illegal_count <= illegal_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr[ptr_w-1:0]] <= pwdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic [31:0]               instr,
    input  logic                      instr_valid,
    output logic                      instr_take,
    output rvx_pkg::reg_addr_t        rs1,
    output rvx_pkg::reg_addr_t        rs2,
    input  logic [rvx_pkg::xlen-1:0]  rdata1,
    input  logic [rvx_pkg::xlen-1:0]  rdata2,
    input  rvx_pkg::fwd_t             fwd_e,
    input  rvx_pkg::fwd_t             fwd_w,
    output rvx_pkg::de_payload_t      de_out,
    output logic                      de_valid,
    output logic                      illegal
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic                      is_op;
    logic                      is_op_imm;
    logic                      is_lui;
    logic                      funct7_ok;
    logic                      legal;
    logic [rvx_pkg::xlen-1:0]  imm_i;
    logic [rvx_pkg::xlen-1:0]  imm_u;
    logic [rvx_pkg::xlen-1:0]  rs1_val;
    logic [rvx_pkg::xlen-1:0]  rs2_val;
    rvx_pkg::alu_op_e          alu_op;

    // Execute has the younger value, so it wins over write-back.
    function automatic logic [rvx_pkg::xlen-1:0] forward(
        input rvx_pkg::reg_addr_t        src,
        input logic [rvx_pkg::xlen-1:0]  rf_value,
        input rvx_pkg::fwd_t             e,
        input rvx_pkg::fwd_t             w
    );
        logic [rvx_pkg::xlen-1:0] value;
        value = rf_value;
        if (src != '0 && w.valid && w.reg_write && w.rd == src) begin
            value = w.value;
        end
        if (src != '0 && e.valid && e.reg_write && e.rd == src) begin
            value = e.value;
        end
        return value;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign is_op     = opcode == rvx_pkg::opc_op;
    assign is_op_imm = opcode == rvx_pkg::opc_op_imm;
    assign is_lui    = opcode == rvx_pkg::opc_lui;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // Only add/sub and the right shifts allow funct7 bit 5.
    always_comb begin
        funct7_ok = 1'b1;
        if (is_op) begin
            if (funct3 == 3'b000 || funct3 == 3'b101) begin
                funct7_ok = funct7 == 7'h00 || funct7 == 7'h20;
            end else begin
                funct7_ok = funct7 == 7'h00;
            end
        end else if (is_op_imm) begin
            if (funct3 == 3'b001) begin
                funct7_ok = funct7 == 7'h00;
            end else if (funct3 == 3'b101) begin
                funct7_ok = funct7 == 7'h00 || funct7 == 7'h20;
            end
        end
    end

    always_comb begin
        if (is_lui) begin
            alu_op = rvx_pkg::alu_add;
        end else begin
            case (funct3)
                3'b000:  alu_op = (is_op && funct7[5]) ? rvx_pkg::alu_sub : rvx_pkg::alu_add;
                3'b001:  alu_op = rvx_pkg::alu_sll;
                3'b010:  alu_op = rvx_pkg::alu_slt;
                3'b011:  alu_op = rvx_pkg::alu_sltu;
                3'b100:  alu_op = rvx_pkg::alu_xor;
                3'b101:  alu_op = funct7[5] ? rvx_pkg::alu_sra : rvx_pkg::alu_srl;
                3'b110:  alu_op = rvx_pkg::alu_or;
                default: alu_op = rvx_pkg::alu_and;
            endcase
        end
    end

    assign legal = (is_op || is_op_imm || is_lui) && funct7_ok;

    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];
    assign rs1_val = forward(rs1, rdata1, fwd_e, fwd_w);
    assign rs2_val = forward(rs2, rdata2, fwd_e, fwd_w);

    always_comb begin
        de_out.reg_write = legal;
        de_out.alu_op    = alu_op;
        de_out.opa       = is_lui ? '0 : rs1_val;
        de_out.opb       = is_op ? rs2_val : (is_lui ? imm_u : imm_i);
        de_out.rd        = instr[11:7];
        de_out.rs1       = rs1;
        de_out.rs2       = rs2;
        de_out.rs1_used  = is_op || is_op_imm;
        de_out.rs2_used  = is_op;
    end

    assign instr_take = instr_valid;    // Nothing stalls, so the head is always consumed.
    assign de_valid   = instr_valid;
    assign illegal    = instr_valid && !legal;

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  rvx_pkg::de_payload_t de_in,
    input  logic                 de_valid,
    output rvx_pkg::ew_payload_t ew_out,
    output rvx_pkg::fwd_t        fwd_e
);

    logic [rvx_pkg::xlen-1:0] a;
    logic [rvx_pkg::xlen-1:0] b;
    logic [4:0]               shamt;
    logic [rvx_pkg::xlen-1:0] result;

    assign a     = de_in.opa;
    assign b     = de_in.opb;
    assign shamt = b[4:0];      // RV32I uses only the low five bits for shifts.

    always_comb begin
        case (de_in.alu_op)
            rvx_pkg::alu_add:  result = a + b;
            rvx_pkg::alu_sub:  result = a - b;
            rvx_pkg::alu_sll:  result = a << shamt;
            rvx_pkg::alu_slt:  result = {{(rvx_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            rvx_pkg::alu_sltu: result = {{(rvx_pkg::xlen-1){1'b0}}, a < b};
            rvx_pkg::alu_xor:  result = a ^ b;
            rvx_pkg::alu_srl:  result = a >> shamt;
            rvx_pkg::alu_sra:  result = $signed(a) >>> shamt;
            rvx_pkg::alu_or:   result = a | b;
            rvx_pkg::alu_and:  result = a & b;
            default:           result = '0;
        endcase
    end

    always_comb begin
        ew_out.reg_write = de_in.reg_write;
        ew_out.rd        = de_in.rd;
        ew_out.result    = result;
    end

    // Decode sees this result one cycle before it reaches the register file.
    always_comb begin
        fwd_e.valid     = de_valid;
        fwd_e.reg_write = de_in.reg_write;
        fwd_e.rd        = de_in.rd;
        fwd_e.value     = result;
    end

endmodule

`default_nettype wire

// ==== hw/result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  rvx_pkg::ew_payload_t      ew_in,
    input  logic                      ew_valid,
    input  rvx_pkg::reg_addr_t        rs1,
    input  rvx_pkg::reg_addr_t        rs2,
    output logic [rvx_pkg::xlen-1:0]  rdata1,
    output logic [rvx_pkg::xlen-1:0]  rdata2,
    input  rvx_pkg::reg_addr_t        dbg_addr,
    output logic [rvx_pkg::xlen-1:0]  rdata_dbg,
    output rvx_pkg::fwd_t             fwd_w,
    output logic [15:0]               retired_count
);

    logic [rvx_pkg::xlen-1:0] regs [1:31];  // x0 has no storage.
    logic                     write_en;

    assign write_en = ew_valid && ew_in.reg_write && ew_in.rd != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[ew_in.rd] <= ew_in.result;
        end
    end

    // Every valid item that reaches this stage retires.
    always_ff @(posedge clk) begin
        if (reset) begin
            retired_count <= '0;
        end else if (ew_valid) begin
            retired_count <= retired_count + 1'b1;
        end
    end

    assign rdata1    = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2    = (rs2 == '0) ? '0 : regs[rs2];
    assign rdata_dbg = (dbg_addr == '0) ? '0 : regs[dbg_addr];

    always_comb begin
        fwd_w.valid     = ew_valid;
        fwd_w.reg_write = ew_in.reg_write;
        fwd_w.rd        = ew_in.rd;
        fwd_w.value     = ew_in.result;
    end

endmodule

`default_nettype wire

// ==== hw/rvx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvx_top #(
    parameter int queue_depth = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [31:0]               instr;
    logic                      instr_valid;
    logic                      instr_take;
    logic                      illegal;
    logic                      pipe_busy;
    rvx_pkg::reg_addr_t        rs1;
    rvx_pkg::reg_addr_t        rs2;
    rvx_pkg::reg_addr_t        dbg_addr;
    logic [rvx_pkg::xlen-1:0]  rdata1;
    logic [rvx_pkg::xlen-1:0]  rdata2;
    logic [rvx_pkg::xlen-1:0]  rdata_dbg;
    logic [15:0]               retired_count;
    rvx_pkg::fwd_t             fwd_e;
    rvx_pkg::fwd_t             fwd_w;
    rvx_pkg::de_payload_t      de_d;
    rvx_pkg::de_payload_t      de_q;
    logic                      de_valid_d;
    logic                      de_valid_q;
    rvx_pkg::ew_payload_t      ew_d;
    rvx_pkg::ew_payload_t      ew_q;
    logic                      ew_valid_q;

    assign pipe_busy = de_valid_q || ew_valid_q;

    apb_front #(
        .queue_depth (queue_depth)
    ) apb_front_i (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .instr_take    (instr_take),
        .illegal       (illegal),
        .pipe_busy     (pipe_busy),
        .dbg_addr      (dbg_addr),
        .rdata_dbg     (rdata_dbg),
        .retired_count (retired_count)
    );

    decode_stage decode_i (
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_take  (instr_take),
        .rs1         (rs1),
        .rs2         (rs2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .fwd_e       (fwd_e),
        .fwd_w       (fwd_w),
        .de_out      (de_d),
        .de_valid    (de_valid_d),
        .illegal     (illegal)
    );

    stage_register #(
        .payload_t (rvx_pkg::de_payload_t)
    ) de_reg_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (illegal),      // Illegal words become bubbles.
        .in_valid  (de_valid_d),
        .in_data   (de_d),
        .out_valid (de_valid_q),
        .out_data  (de_q)
    );

    execute_stage execute_i (
        .de_in    (de_q),
        .de_valid (de_valid_q),
        .ew_out   (ew_d),
        .fwd_e    (fwd_e)
    );

    stage_register #(
        .payload_t (rvx_pkg::ew_payload_t)
    ) ew_reg_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (de_valid_q),
        .in_data   (ew_d),
        .out_valid (ew_valid_q),
        .out_data  (ew_q)
    );

    result_stage result_i (
        .clk           (clk),
        .reset         (reset),
        .ew_in         (ew_q),
        .ew_valid      (ew_valid_q),
        .rs1           (rs1),
        .rs2           (rs2),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .dbg_addr      (dbg_addr),
        .rdata_dbg     (rdata_dbg),
        .fwd_w         (fwd_w),
        .retired_count (retired_count)
    );

endmodule

`default_nettype wire

// ==== verif/rvx_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvx_sva (
    input logic        clk,
    input logic        reset,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [7:0]  paddr,
    input logic [31:0] pwdata,
    input logic        pready,
    input logic        pslverr,
    input logic        pipe_busy
);

    int failures = 0;   // The testbench reads this at the end of the run.

    penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel)
    else begin
        failures++;
        $error("penable high without psel");
    end

    // An access phase opens only after a setup phase of the same transfer.
    access_after_setup: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel))
    else begin
        failures++;
        $error("access phase without a setup phase");
    end

    apb_stable_while_waiting: assert property (@(posedge clk) disable iff (reset)
        psel && penable && !pready |=> psel && penable && $stable(pwrite)
            && $stable(paddr) && $stable(pwdata))
    else begin
        failures++;
        $error("APB request changed before pready");
    end

    pslverr_with_pready: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> pready)
    else begin
        failures++;
        $error("pslverr without pready");
    end

    read_after_drain: assert property (@(posedge clk) disable iff (reset)
        pready && !pwrite && !pslverr && paddr >= rvx_pkg::addr_reg_base |-> !pipe_busy)
    else begin
        failures++;
        $error("register read completed with the pipeline busy");
    end

endmodule

bind rvx_top rvx_sva sva_i (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .pipe_busy (pipe_busy)
);

`default_nettype wire

// ==== verif/rvx_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvx_tb;

    localparam int    timeout_cycles = 200;
    localparam string trace_path     = "verif/rvx_trace.txt";

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] model_regs [32];
    logic [31:0] rng_state;
    bit          timed_out;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    string       test_name;

    rvx_top #(
        .queue_depth (4)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (!timed_out) begin
            check_count++;
            test_checks++;
            if (got !== expected) begin
                error_count++;
                test_errors++;
                $display("[ERROR] t=%0t %s: got %08h, expected %08h", $time, what, got,
                         expected);
            end
        end
    endtask

    // One APB transfer; pready is sampled at the falling edge, where it is stable.
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        rdata = '0;
        err   = 1'b0;
        if (!timed_out) begin
            @(posedge clk);
            psel    <= 1'b1;
            penable <= 1'b0;
            pwrite  <= write;
            paddr   <= addr;
            pwdata  <= wdata;
            @(posedge clk);
            penable <= 1'b1;
            waited = 0;
            @(negedge clk);
            while (!pready && waited < timeout_cycles) begin
                waited++;
                @(negedge clk);
            end
            if (!pready) begin
                timed_out = 1'b1;
                $display("Timeout: no pready within %0d cycles at address %02h",
                         timeout_cycles, addr);
            end else begin
                rdata = prdata;
                err   = pslverr;
                @(posedge clk);
                psel    <= 1'b0;
                penable <= 1'b0;
            end
        end
    endtask

    // Architectural effect of one instruction word, straight from the RV32I rules.
    task automatic model_step(input logic [31:0] word);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        legal;
        opcode = word[6:0];
        f3     = word[14:12];
        f7     = word[31:25];
        a      = model_regs[word[19:15]];
        b      = (opcode == 7'h33) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        case (opcode)
            7'h37:   legal = 1'b1;
            7'h33:   legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            7'h13:   legal = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00
                             || (f3 == 3'd5 && f7 == 7'h20);
            default: legal = 1'b0;
        endcase
        case (f3)
            3'd0: r = (opcode == 7'h33 && f7[5]) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (f7[5]) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (opcode == 7'h37) begin
            r = {word[31:12], 12'h000};
        end
        if (legal && word[11:7] != 5'd0) begin
            model_regs[word[11:7]] = r;
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Always a legal OP or OP-IMM word; funct7 is only set where the ISA allows it.
    function automatic logic [31:0] random_instr(input logic [31:0] r);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [31:0] word;
        f3  = r[17:15];
        imm = r[31:20];
        if (r[18]) begin
            f7   = (r[19] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            word = {f7, r[14:10], r[9:5], f3, r[4:0], 7'h33};
        end else begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = (f3 == 3'd5 && r[19]) ? 7'h20 : 7'h00;
            end
            word = {imm, r[9:5], f3, r[4:0], 7'h13};
        end
        return word;
    endfunction

    task automatic run_burst(input int count);
        logic [31:0] word;
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            word = random_instr(rng_state);
            model_step(word);
            apb_transfer(1'b1, rvx_pkg::addr_instr, word, rdata, err);
            check_value({31'd0, err}, 32'd0, $sformatf("pslverr on random word %08h", word));
        end
        for (int i = 0; i < 32; i++) begin
            apb_transfer(1'b0, rvx_pkg::addr_reg_base + 8'(i * 4), 32'd0, rdata, err);
            check_value(rdata, model_regs[i], $sformatf("x%0d after random burst", i));
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic run_trace();
        int          fd;
        int          code;
        int          idx;
        int          wr;
        int          count;
        logic [7:0]  op;
        logic [31:0] value;
        logic [31:0] rdata;
        logic        err;
        bit          at_end;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the trace file %s", trace_path);
        end else begin
            at_end = 1'b0;
            while (!at_end && !timed_out) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    at_end = 1'b1;
                end else begin
                    case (op)
                        "T": begin
                            finish_test();
                            code = $fscanf(fd, " %s", test_name);
                        end
                        "W": begin
                            code = $fscanf(fd, " %h", value);
                            model_step(value);
                            apb_transfer(1'b1, rvx_pkg::addr_instr, value, rdata, err);
                            check_value({31'd0, err}, 32'd0,
                                        $sformatf("pslverr writing %08h", value));
                        end
                        "R": begin
                            code = $fscanf(fd, " %d %h", idx, value);
                            apb_transfer(1'b0, rvx_pkg::addr_reg_base + 8'(idx * 4), 32'd0,
                                         rdata, err);
                            check_value({31'd0, err}, 32'd0, $sformatf("pslverr on x%0d", idx));
                            check_value(rdata, value, $sformatf("x%0d", idx));
                        end
                        "S": begin
                            code = $fscanf(fd, " %h", value);
                            apb_transfer(1'b0, rvx_pkg::addr_status, 32'd0, rdata, err);
                            check_value({31'd0, err}, 32'd0, "pslverr on status");
                            check_value(rdata, value, "status word");
                        end
                        "E": begin
                            code = $fscanf(fd, " %d %h", wr, value);
                            apb_transfer(wr != 0, value[7:0], 32'h5a5a_a5a5, rdata, err);
                            check_value({31'd0, err}, 32'd1,
                                        $sformatf("pslverr at address %02h", value[7:0]));
                        end
                        "X": begin
                            code = $fscanf(fd, " %d", count);
                            run_burst(count);
                        end
                        "#": ;
                        default: begin
                            error_count++;
                            $display("Unknown record '%c' in the trace file", op);
                        end
                    endcase
                    skip_line(fd);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rng_state = 32'd58175;
        timed_out = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        run_trace();
        finish_test();
        $display("Total: %0d checks, %0d errors, %0d assertion failures", check_count,
                 error_count, dut_i.sva_i.failures);
        if (error_count == 0 && !timed_out && dut_i.sva_i.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bender.yml ====
package:
  name: rvx

sources:
  # Package first, then the design from the leaves up to the top level.
  - hw/rvx_pkg.sv
  - hw/stage_register.sv
  - hw/apb_front.sv
  - hw/decode_stage.sv
  - hw/execute_stage.sv
  - hw/result_stage.sv
  - hw/rvx_top.sv

  - target: test
    files:
      - verif/rvx_sva.sv
      - verif/rvx_tb.sv

// ==== files.f ====
hw/rvx_pkg.sv
hw/stage_register.sv
hw/apb_front.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/rvx_top.sv
verif/rvx_sva.sv
verif/rvx_tb.sv

// ==== verif/rvx_trace.txt ====
# T name | W instr | R reg(dec) value | S status | E write(0/1) addr | X count(dec)
# Values and addresses in hex; text after the operands is ignored.
T alu
W 800000B7  lui   x1, 0x80000
W FFB00113  addi  x2, x0, -5
W 00700193  addi  x3, x0, 7
W 00208233  add   x4, x1, x2
W 402082B3  sub   x5, x1, x2
W 00311333  sll   x6, x2, x3
W 0030A3B3  slt   x7, x1, x3
W 0030B433  sltu  x8, x1, x3
W 0020C4B3  xor   x9, x1, x2
W 0030D533  srl   x10, x1, x3
W 4030D5B3  sra   x11, x1, x3
W 0030E633  or    x12, x1, x3
W 003176B3  and   x13, x2, x3
W FFF1A713  slti  x14, x3, -1
W FFF1B793  sltiu x15, x3, -1
W FFF14813  xori  x16, x2, -1
W 40115893  srai  x17, x2, 1
W 01C15913  srli  x18, x2, 28
W 01F19993  slli  x19, x3, 31
W 5550EA13  ori   x20, x1, 0x555
W 0F017A93  andi  x21, x2, 0xf0
R 4 7FFFFFFB
R 5 80000005
R 6 FFFFFD80
R 7 00000001
R 8 00000000
R 9 7FFFFFFB
R 10 01000000
R 11 FF000000
R 12 80000007
R 13 00000003
R 14 00000000
R 15 00000001
R 16 00000004
R 17 FFFFFFFD
R 18 0000000F
R 19 80000000
R 20 80000555
R 21 000000F0
T dependent
W 06400B13  addi  x22, x0, 100
W 016B0BB3  add   x23, x22, x22
W 416B8C33  sub   x24, x23, x22
W 017C4B33  xor   x22, x24, x23
R 22 000000AC
R 23 000000C8
R 24 00000064
T x0
W 00518013  addi  x0, x3, 5
W FFFFF037  lui   x0, 0xfffff
W 00300CB3  add   x25, x0, x3
R 0 00000000
R 25 00000007
T illegal
W FFFFFFFF  opcode 0x7f
W 0000006F  jal
W 00208203  load into x4
W 02208233  OP with funct7 0x01 into x4
W 40119993  slli with funct7 0x20 into x19
R 4 7FFFFFFB
R 19 80000000
S 0005001C  5 illegal, 28 retired
T apb_errors
E 1 04  write to status
E 1 84  write to x1
E 1 10  write to unmapped
E 0 00  read of the instruction port
E 0 08  read of unmapped
E 0 82  unaligned register read
S 0005001C
R 1 80000000
T random
X 12
X 20
S 0005003C  5 illegal, 60 retired
R 0 00000000
